/* lane_consts.svh */
// Lane constants
// Sizes of the register file slice, the element width and the
// depth of the operand queues

`ifndef LANE_CONSTS_SVH
`define LANE_CONSTS_SVH

// Vector registers held by the lane
`define LANE_NR_VREGS 8

// Elements per vector register
`define LANE_ELEMS 8

// Element width in bits
`define LANE_ELEN 32

// Entries per operand queue
`define LANE_QUEUE_DEPTH 4

`endif

/* lane_pkg.sv */
// Lane package
// Shared element, address and command types of the vector lane

`include "lane_consts.svh"

package lane_pkg;

  typedef logic [`LANE_ELEN-1:0] elen_t;
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0] vreg_t;
  typedef logic [$clog2(`LANE_ELEMS)-1:0] elem_idx_t;
  // Holds 1 to LANE_ELEMS
  typedef logic [$clog2(`LANE_ELEMS+1)-1:0] vlen_t;

  // Address of one element in the register file
  typedef struct packed {
    vreg_t     vreg;
    elem_idx_t elem;
  } vaddr_t;

  typedef enum logic [2:0] {VADD, VSUB, VAND, VOR, VXOR, VSTORE} vop_e;

  // Instruction from the main sequencer
  // A store takes its data register from the vd field
  typedef struct packed {
    vop_e  op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    vlen_t vl;
  } pe_req_t;

  typedef struct packed {
    vreg_t vs1;
    vreg_t vs2;
    vlen_t vl;
    logic  is_store;
  } operand_request_t;

  typedef struct packed {
    vop_e  op;
    vreg_t vd;
    vlen_t vl;
  } vfu_operation_t;

  // Register file write from the ALU or the load port
  typedef struct packed {
    vaddr_t addr;
    elen_t  wdata;
  } result_t;

endpackage

/* operand_queue.sv */
// Operand queue
// Circular FIFO between the register file and a consumer. Each pop
// hands one credit back to the operand requester

`include "lane_consts.svh"

module operand_queue (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            push_i,
  input  lane_pkg::elen_t data_i,
  output lane_pkg::elen_t data_o,
  output logic            valid_o,
  input  logic            pop_i,
  output logic            credit_o
);
  import lane_pkg::*;

  localparam int unsigned Depth = `LANE_QUEUE_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);

  elen_t             mem [Depth];
  logic  [PtrW-1:0]  wr_ptr_q;
  logic  [PtrW-1:0]  rd_ptr_q;
  logic  [PtrW:0]    count_q;
  logic              do_pop;

  assign valid_o  = (count_q != '0);
  assign data_o   = mem[rd_ptr_q];
  assign do_pop   = pop_i && valid_o;
  assign credit_o = do_pop;

  // Pointers wrap on their own for a power of two depth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PtrW+1)'(push_i) - (PtrW+1)'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Credit flow in the requester keeps the queue from overflowing
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> count_q < (PtrW+1)'(Depth));

endmodule

/* vector_regfile.sv */
// Vector register file
// Flip-flop storage for the lane's elements with two registered read
// ports and one write port

`include "lane_consts.svh"

module vector_regfile (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  lane_pkg::vaddr_t [1:0] raddr_i,
  input  logic             [1:0] ren_i,
  output lane_pkg::elen_t  [1:0] rdata_o,
  input  lane_pkg::vaddr_t       waddr_i,
  input  lane_pkg::elen_t        wdata_i,
  input  logic                   wen_i
);
  import lane_pkg::*;

  elen_t mem [`LANE_NR_VREGS][`LANE_ELEMS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < `LANE_NR_VREGS; v++) begin
        for (int e = 0; e < `LANE_ELEMS; e++) begin
          mem[v][e] <= '0;
        end
      end
      rdata_o <= '0;
    end else begin
      if (wen_i) begin
        mem[waddr_i.vreg][waddr_i.elem] <= wdata_i;
      end
      // A read in the same cycle as a write returns the old value
      for (int p = 0; p < 2; p++) begin
        if (ren_i[p]) begin
          rdata_o[p] <= mem[raddr_i[p].vreg][raddr_i[p].elem];
        end
      end
    end
  end

endmodule

/* vector_alu.sv */
// Vector integer ALU
// Pops one element pair from the operand queues, computes the result
// and requests its write-back, then reports the end of the instruction

module vector_alu (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  lane_pkg::vfu_operation_t vfu_operation_i,
  input  logic                     vfu_operation_valid_i,
  input  lane_pkg::elen_t          opa_i,
  input  logic                     opa_valid_i,
  output logic                     opa_pop_o,
  input  lane_pkg::elen_t          opb_i,
  input  logic                     opb_valid_i,
  output logic                     opb_pop_o,
  output logic                     result_req_o,
  output lane_pkg::result_t        result_o,
  input  logic                     result_gnt_i,
  output logic                     alu_done_o
);
  import lane_pkg::*;

  vfu_operation_t op_q;
  result_t        result_q;
  vlen_t          cnt_q;
  logic           active_q;
  logic           pending_q;
  logic           pop;
  logic           last_elem;
  elen_t          res;

  // One element in flight at a time
  assign pop       = active_q && opa_valid_i && opb_valid_i && !pending_q;
  assign opa_pop_o = pop;
  assign opb_pop_o = pop;
  assign last_elem = (cnt_q == op_q.vl - 1'b1);

  assign result_req_o = pending_q;
  assign result_o     = result_q;
  assign alu_done_o   = pending_q && result_gnt_i && last_elem;

  always_comb begin
    case (op_q.op)
      VADD:    res = opa_i + opb_i;
      VSUB:    res = opa_i - opb_i;
      VAND:    res = opa_i & opb_i;
      VOR:     res = opa_i | opb_i;
      VXOR:    res = opa_i ^ opb_i;
      default: res = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q  <= 1'b0;
      pending_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      if (vfu_operation_valid_i) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end
      if (pop) begin
        pending_q <= 1'b1;
      end
      // Element counts once its write is granted
      if (pending_q && result_gnt_i) begin
        pending_q <= 1'b0;
        cnt_q     <= cnt_q + 1'b1;
        if (last_elem) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (vfu_operation_valid_i) begin
      op_q <= vfu_operation_i;
    end
    if (pop) begin
      result_q.addr.vreg <= op_q.vd;
      result_q.addr.elem <= elem_idx_t'(cnt_q);
      result_q.wdata     <= res;
    end
  end

  a_elem_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_req_o |-> vlen_t'(result_o.addr.elem) < op_q.vl);

endmodule

/* operand_requester.sv */
// Operand requester
// Steps through the elements of an instruction and reads its sources
// while the target queues have credits. Also arbitrates the single
// register file write port between the ALU and the load port

`include "lane_consts.svh"

module operand_requester (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  lane_pkg::operand_request_t operand_request_i,
  input  logic                       operand_request_valid_i,
  output logic                       operand_request_ready_o,
  output lane_pkg::vaddr_t     [1:0] vrf_raddr_o,
  output logic               [1:0]   vrf_ren_o,
  output lane_pkg::vaddr_t           vrf_waddr_o,
  output lane_pkg::elen_t            vrf_wdata_o,
  output logic                       vrf_wen_o,
  output logic               [2:0]   queue_push_o,
  input  logic               [2:0]   queue_credit_i,
  input  logic                       alu_result_req_i,
  input  lane_pkg::result_t          alu_result_i,
  output logic                       alu_result_gnt_o,
  input  logic                       ldu_result_req_i,
  input  lane_pkg::result_t          ldu_result_i,
  output logic                       ldu_result_gnt_o,
  output logic                       store_done_o
);
  import lane_pkg::*;

  localparam int unsigned NrQueues = 3;
  localparam int unsigned Depth    = `LANE_QUEUE_DEPTH;
  localparam int unsigned CntW     = $clog2(Depth + 1);

  operand_request_t                    req_q;
  logic                                active_q;
  logic                                store_wait_q;
  vlen_t                               cnt_q;
  logic             [NrQueues-1:0]     push_q;
  logic             [NrQueues-1:0]     need;
  logic             [NrQueues-1:0][CntW-1:0] credit_q;
  logic             [NrQueues-1:0][CntW-1:0] credit_d;
  logic                                issue;
  logic                                last_elem;
  result_t                             wr;

  assign operand_request_ready_o = !active_q && !store_wait_q;

  // Store feeds queue 2 only, arithmetic ops feed queues 0 and 1
  assign need      = req_q.is_store ? 3'b100 : 3'b011;
  assign last_elem = (cnt_q == req_q.vl - 1'b1);

  always_comb begin
    issue = active_q;
    for (int i = 0; i < NrQueues; i++) begin
      if (need[i] && credit_q[i] == '0) begin
        issue = 1'b0;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NrQueues; i++) begin
      credit_d[i] = credit_q[i] - CntW'(issue && need[i]) + CntW'(queue_credit_i[i]);
    end
  end

  assign vrf_raddr_o[0] = {req_q.vs1, elem_idx_t'(cnt_q)};
  assign vrf_raddr_o[1] = {req_q.vs2, elem_idx_t'(cnt_q)};
  assign vrf_ren_o      = {issue && !req_q.is_store, issue};

  // Read data shows up one cycle after the enable
  assign queue_push_o = push_q;

  // Last store element has left once all credits are back
  assign store_done_o = store_wait_q && (credit_q[2] == CntW'(Depth));

  ////////////////////////////////////////////////////////////////////////////
  // Write arbitration, ALU first

  assign alu_result_gnt_o = alu_result_req_i;
  assign ldu_result_gnt_o = ldu_result_req_i && !alu_result_req_i;
  assign wr               = alu_result_req_i ? alu_result_i : ldu_result_i;
  assign vrf_wen_o        = alu_result_req_i || ldu_result_req_i;
  assign vrf_waddr_o      = wr.addr;
  assign vrf_wdata_o      = wr.wdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q     <= 1'b0;
      store_wait_q <= 1'b0;
      cnt_q        <= '0;
      push_q       <= '0;
      credit_q     <= {NrQueues{CntW'(Depth)}};
    end else begin
      credit_q <= credit_d;
      push_q   <= issue ? need : '0;
      if (store_done_o) begin
        store_wait_q <= 1'b0;
      end
      if (operand_request_valid_i && operand_request_ready_o) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (issue) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_elem) begin
          active_q     <= 1'b0;
          store_wait_q <= req_q.is_store;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (operand_request_valid_i && operand_request_ready_o) begin
      req_q <= operand_request_i;
    end
  end

  for (genvar i = 0; i < NrQueues; i++) begin : gen_credit_check
    // Queues never return more credits than they were given
    a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_q[i] <= CntW'(Depth));
  end

endmodule

/* lane_sequencer.sv */
// Lane sequencer
// Takes one instruction at a time, splits it into an operand request
// and an ALU operation, and signals completion

module lane_sequencer (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  lane_pkg::pe_req_t          pe_req_i,
  input  logic                       pe_req_valid_i,
  output logic                       pe_req_ready_o,
  output logic                       pe_done_o,
  output lane_pkg::operand_request_t operand_request_o,
  output logic                       operand_request_valid_o,
  input  logic                       operand_request_ready_i,
  output lane_pkg::vfu_operation_t   vfu_operation_o,
  output logic                       vfu_operation_valid_o,
  input  logic                       alu_done_i,
  input  logic                       store_done_i
);
  import lane_pkg::*;

  pe_req_t req_q;
  logic    busy_q;
  logic    oreq_pending_q;
  logic    vfu_valid_q;
  logic    accept;
  logic    is_store;

  assign pe_req_ready_o = !busy_q;
  assign accept         = pe_req_valid_i && pe_req_ready_o;
  assign is_store       = (req_q.op == VSTORE);

  // Completion source depends on the instruction type
  assign pe_done_o = busy_q && !oreq_pending_q && (is_store ? store_done_i : alu_done_i);

  always_comb begin
    operand_request_o.vs1      = is_store ? req_q.vd : req_q.vs1;
    operand_request_o.vs2      = req_q.vs2;
    operand_request_o.vl       = req_q.vl;
    operand_request_o.is_store = is_store;
    vfu_operation_o.op         = req_q.op;
    vfu_operation_o.vd         = req_q.vd;
    vfu_operation_o.vl         = req_q.vl;
  end

  assign operand_request_valid_o = oreq_pending_q;
  assign vfu_operation_valid_o   = vfu_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q         <= 1'b0;
      oreq_pending_q <= 1'b0;
      vfu_valid_q    <= 1'b0;
    end else begin
      // ALU pulse only for arithmetic ops
      vfu_valid_q <= accept && (pe_req_i.op != VSTORE);
      if (accept) begin
        busy_q         <= 1'b1;
        oreq_pending_q <= 1'b1;
      end else begin
        if (operand_request_valid_o && operand_request_ready_i) begin
          oreq_pending_q <= 1'b0;
        end
        if (pe_done_o) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= pe_req_i;
    end
  end

  // Completions only come from the unit that runs the held instruction
  a_alu_done_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alu_done_i |-> busy_q && !oreq_pending_q && !is_store);
  a_store_done_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    store_done_i |-> busy_q && !oreq_pending_q && is_store);

endmodule

/* lane.sv */
// Vector lane
// Holds a slice of the vector register file and executes integer
// element-wise instructions and register stores, one at a time

module lane (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  lane_pkg::pe_req_t pe_req_i,
  input  logic              pe_req_valid_i,
  output logic              pe_req_ready_o,
  output logic              pe_done_o,
  input  logic              ldu_result_req_i,
  input  lane_pkg::result_t ldu_result_i,
  output logic              ldu_result_gnt_o,
  output lane_pkg::elen_t   stu_operand_o,
  output logic              stu_operand_valid_o,
  input  logic              stu_operand_ready_i
);
  import lane_pkg::*;

  operand_request_t operand_request;
  logic             operand_request_valid;
  logic             operand_request_ready;
  vfu_operation_t   vfu_operation;
  logic             vfu_operation_valid;
  logic             alu_done;
  logic             store_done;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer

  lane_sequencer i_lane_sequencer (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .pe_req_i               (pe_req_i),
    .pe_req_valid_i         (pe_req_valid_i),
    .pe_req_ready_o         (pe_req_ready_o),
    .pe_done_o              (pe_done_o),
    .operand_request_o      (operand_request),
    .operand_request_valid_o(operand_request_valid),
    .operand_request_ready_i(operand_request_ready),
    .vfu_operation_o        (vfu_operation),
    .vfu_operation_valid_o  (vfu_operation_valid),
    .alu_done_i             (alu_done),
    .store_done_i           (store_done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Operand requester and register file

  vaddr_t  [1:0] vrf_raddr;
  logic    [1:0] vrf_ren;
  elen_t   [1:0] vrf_rdata;
  vaddr_t        vrf_waddr;
  elen_t         vrf_wdata;
  logic          vrf_wen;
  // Queue 0 and 1 feed the ALU, queue 2 the store port
  logic    [2:0] queue_push;
  logic    [2:0] queue_credit;
  logic          alu_result_req;
  result_t       alu_result;
  logic          alu_result_gnt;

  operand_requester i_operand_requester (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .operand_request_i      (operand_request),
    .operand_request_valid_i(operand_request_valid),
    .operand_request_ready_o(operand_request_ready),
    .vrf_raddr_o            (vrf_raddr),
    .vrf_ren_o              (vrf_ren),
    .vrf_waddr_o            (vrf_waddr),
    .vrf_wdata_o            (vrf_wdata),
    .vrf_wen_o              (vrf_wen),
    .queue_push_o           (queue_push),
    .queue_credit_i         (queue_credit),
    .alu_result_req_i       (alu_result_req),
    .alu_result_i           (alu_result),
    .alu_result_gnt_o       (alu_result_gnt),
    .ldu_result_req_i       (ldu_result_req_i),
    .ldu_result_i           (ldu_result_i),
    .ldu_result_gnt_o       (ldu_result_gnt_o),
    .store_done_o           (store_done)
  );

  vector_regfile i_vrf (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .raddr_i(vrf_raddr),
    .ren_i  (vrf_ren),
    .rdata_o(vrf_rdata),
    .waddr_i(vrf_waddr),
    .wdata_i(vrf_wdata),
    .wen_i  (vrf_wen)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Operand queues

  elen_t alu_opa;
  elen_t alu_opb;
  logic  alu_opa_valid;
  logic  alu_opb_valid;
  logic  alu_opa_pop;
  logic  alu_opb_pop;

  operand_queue i_opqueue_alu_a (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (queue_push[0]),
    .data_i  (vrf_rdata[0]),
    .data_o  (alu_opa),
    .valid_o (alu_opa_valid),
    .pop_i   (alu_opa_pop),
    .credit_o(queue_credit[0])
  );

  operand_queue i_opqueue_alu_b (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (queue_push[1]),
    .data_i  (vrf_rdata[1]),
    .data_o  (alu_opb),
    .valid_o (alu_opb_valid),
    .pop_i   (alu_opb_pop),
    .credit_o(queue_credit[1])
  );

  // Store data comes out of read port 0
  operand_queue i_opqueue_store (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (queue_push[2]),
    .data_i  (vrf_rdata[0]),
    .data_o  (stu_operand_o),
    .valid_o (stu_operand_valid_o),
    .pop_i   (stu_operand_ready_i),
    .credit_o(queue_credit[2])
  );

  ////////////////////////////////////////////////////////////////////////////
  // ALU

  vector_alu i_valu (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .vfu_operation_i      (vfu_operation),
    .vfu_operation_valid_i(vfu_operation_valid),
    .opa_i                (alu_opa),
    .opa_valid_i          (alu_opa_valid),
    .opa_pop_o            (alu_opa_pop),
    .opb_i                (alu_opb),
    .opb_valid_i          (alu_opb_valid),
    .opb_pop_o            (alu_opb_pop),
    .result_req_o         (alu_result_req),
    .result_o             (alu_result),
    .result_gnt_i         (alu_result_gnt),
    .alu_done_o           (alu_done)
  );

endmodule

/* tb_lane.sv */
// Lane testbench
// Fills the register file through the load port, runs random integer
// instructions and stores, and checks every stored element against a
// register file model kept in the testbench

`include "lane_consts.svh"

module tb_lane;
  import lane_pkg::*;

  localparam int clk_period      = 100;
  localparam int nr_alu_ops      = 40;
  localparam int nr_stall_stores = 16;
  localparam int op_timeout      = 200;
  // Loads, first stores, ALU ops with their stores, stalled stores
  localparam int nr_ops = `LANE_NR_VREGS * `LANE_ELEMS + `LANE_NR_VREGS
                          + 2 * nr_alu_ops + nr_stall_stores;

  logic    clk;
  logic    rst_n;
  pe_req_t pe_req;
  logic    pe_req_valid;
  logic    pe_req_ready;
  logic    pe_done;
  logic    ldu_result_req;
  result_t ldu_result;
  logic    ldu_result_gnt;
  elen_t   stu_operand;
  logic    stu_operand_valid;
  logic    stu_operand_ready;

  elen_t   model [`LANE_NR_VREGS][`LANE_ELEMS];
  integer  seed;
  int      accept_count;
  int      done_count = 0;
  logic    stall_mode;

  lane lane_inst (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .pe_req_i           (pe_req),
    .pe_req_valid_i     (pe_req_valid),
    .pe_req_ready_o     (pe_req_ready),
    .pe_done_o          (pe_done),
    .ldu_result_req_i   (ldu_result_req),
    .ldu_result_i       (ldu_result),
    .ldu_result_gnt_o   (ldu_result_gnt),
    .stu_operand_o      (stu_operand),
    .stu_operand_valid_o(stu_operand_valid),
    .stu_operand_ready_i(stu_operand_ready)
  );

  always #(clk_period / 2) clk = ~clk;

  // Every completion pulse of the run
  always @(negedge clk) begin
    if (rst_n && pe_done) begin
      done_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Stopping on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // Element-wise result of an integer op
  function automatic elen_t alu_model(input vop_e op, input elen_t a, input elen_t b);
    case (op)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      VOR:     return a | b;
      VXOR:    return a ^ b;
      default: return '0;
    endcase
  endfunction

  task automatic load_element(input vreg_t vreg, input elem_idx_t elem, input elen_t data);
    @(negedge clk);
    ldu_result_req        = 1'b1;
    ldu_result.addr.vreg  = vreg;
    ldu_result.addr.elem  = elem;
    ldu_result.wdata      = data;
    // Idle lane grants in the request cycle
    #(clk_period / 4);
    check_value("ldu_result_gnt_o", 1'b1, ldu_result_gnt);
    // Written at the coming rising edge
    model[vreg][elem] = data;
    @(negedge clk);
    ldu_result_req = 1'b0;
  endtask

  task automatic run_instr(input pe_req_t req);
    elen_t expected [`LANE_ELEMS];
    int    nr_stored;
    int    cycles;
    logic  done_seen;
    logic  take;
    for (int i = 0; i < req.vl; i++) begin
      if (req.op == VSTORE) begin
        expected[i] = model[req.vd][i];
      end else begin
        expected[i] = alu_model(req.op, model[req.vs1][i], model[req.vs2][i]);
      end
    end
    @(negedge clk);
    pe_req       = req;
    pe_req_valid = 1'b1;
    cycles       = 0;
    while (!pe_req_ready) begin
      cycles++;
      assert (cycles < op_timeout) else begin
        $display("Error at time %0t: instruction was never accepted", $time);
        abort_run();
      end
      @(negedge clk);
    end
    accept_count++;
    done_seen = 1'b0;
    nr_stored = 0;
    cycles    = 0;
    while (!done_seen) begin
      @(negedge clk);
      pe_req_valid = 1'b0;
      check_value("pe_req_ready_o", 1'b0, pe_req_ready);
      cycles++;
      assert (cycles < op_timeout) else begin
        $display("Error at time %0t: instruction did not complete", $time);
        abort_run();
      end
      if (pe_done) begin
        done_seen = 1'b1;
      end
      take = stall_mode ? (($random(seed) & 1) == 1) : 1'b1;
      // Element leaves at the next rising edge
      if (stu_operand_valid && take) begin
        assert (req.op == VSTORE && nr_stored < req.vl) else begin
          $display("Error at time %0t: store element came out that was not expected", $time);
          abort_run();
        end
        check_value("stu_operand_o", expected[nr_stored], stu_operand);
        nr_stored++;
      end
      stu_operand_ready = take;
    end
    check_value("stu_operand_o element count", (req.op == VSTORE) ? req.vl : 0, nr_stored);
    if (req.op != VSTORE) begin
      for (int i = 0; i < req.vl; i++) begin
        model[req.vd][i] = expected[i];
      end
    end
    @(negedge clk);
    stu_operand_ready = 1'b1;
    check_value("pe_done_o", 1'b0, pe_done);
    check_value("pe_req_ready_o", 1'b1, pe_req_ready);
    check_value("stu_operand_valid_o", 1'b0, stu_operand_valid);
  endtask

  task automatic store_reg(input vreg_t vreg, input vlen_t vl);
    pe_req_t req;
    req.op  = VSTORE;
    req.vd  = vreg;
    req.vs1 = '0;
    req.vs2 = '0;
    req.vl  = vl;
    run_instr(req);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    pe_req_t req;
    seed              = 33543;
    clk               = 1'b0;
    rst_n             = 1'b0;
    pe_req            = '0;
    pe_req_valid      = 1'b0;
    ldu_result_req    = 1'b0;
    ldu_result        = '0;
    stu_operand_ready = 1'b1;
    stall_mode        = 1'b0;
    accept_count      = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("pe_req_ready_o", 1'b1, pe_req_ready);
    check_value("pe_done_o", 1'b0, pe_done);
    check_value("stu_operand_valid_o", 1'b0, stu_operand_valid);
    check_value("ldu_result_gnt_o", 1'b0, ldu_result_gnt);

    // Fill every register, then read each one back
    for (int v = 0; v < `LANE_NR_VREGS; v++) begin
      for (int e = 0; e < `LANE_ELEMS; e++) begin
        load_element(vreg_t'(v), elem_idx_t'(e), elen_t'($random(seed)));
      end
    end
    for (int v = 0; v < `LANE_NR_VREGS; v++) begin
      store_reg(vreg_t'(v), vlen_t'(`LANE_ELEMS));
    end

    // Random arithmetic, each followed by a full store of vd
    for (int n = 0; n < nr_alu_ops; n++) begin
      req.op  = vop_e'({$random(seed)} % 5);
      req.vd  = vreg_t'({$random(seed)} % `LANE_NR_VREGS);
      req.vs1 = vreg_t'({$random(seed)} % `LANE_NR_VREGS);
      req.vs2 = vreg_t'({$random(seed)} % `LANE_NR_VREGS);
      req.vl  = vlen_t'({$random(seed)} % `LANE_ELEMS + 1);
      run_instr(req);
      store_reg(req.vd, vlen_t'(`LANE_ELEMS));
    end

    // Stores under back-pressure
    stall_mode = 1'b1;
    for (int n = 0; n < nr_stall_stores; n++) begin
      store_reg(vreg_t'({$random(seed)} % `LANE_NR_VREGS),
                vlen_t'({$random(seed)} % `LANE_ELEMS + 1));
    end
    stall_mode = 1'b0;

    @(negedge clk);
    if (done_count == accept_count) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Error at time %0t: pe_done_o pulse count expected %0d, got %0d",
               $time, accept_count, done_count);
      abort_run();
    end
  end

  // Upper bound on the whole run
  initial begin
    #((nr_ops * 200 + 100) * clk_period);
    $display("Watchdog expired before the tests finished");
    abort_run();
  end

endmodule

/* build.f */
+incdir+.
lane_pkg.sv
operand_queue.sv
vector_regfile.sv
vector_alu.sv
operand_requester.sv
lane_sequencer.sv
lane.sv
tb_lane.sv

/* Bender.yml */
package:
  name: vector_lane

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lane_pkg.sv
      - operand_queue.sv
      - vector_regfile.sv
      - vector_alu.sv
      - operand_requester.sv
      - lane_sequencer.sv
      - lane.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lane.sv
